// File: verilog/a8_io_pkg.sv
package a8_io_pkg;

	// ==========================================================================
	// Subsystem constants
	// ==========================================================================

	localparam int NUM_DRIVES     = 8;
	localparam int DRV_W          = $clog2(NUM_DRIVES);
	localparam int MOUSE_STEP_MAX = 10;
	localparam int AXIS_MIN       = -128;
	localparam int AXIS_MAX       = 127;

	localparam logic [7:0] ROM_PAD_BYTE = 8'hFF;

	// ==========================================================================
	// Packed types
	// ==========================================================================

	// Firmware command register with the data word in the low bits
	typedef struct packed {
		logic             io_reset;
		logic             data_rd;
		logic             data_wr;
		logic [DRV_W-1:0] drv_num;
		logic             block_wr;
		logic             block_rd;
		logic             lba_sel;
		logic [31:0]      data;
	} fw_cmd_t;

	// Status byte as seen by the firmware, io_done in bit 0
	typedef struct packed {
		logic             read_only;
		logic [1:0]       file_type;
		logic [DRV_W-1:0] file_no;
		logic             mounted;
		logic             io_done;
	} fw_status_t;

	typedef struct packed {
		logic [NUM_DRIVES-1:0] mount;
		logic                  read_only;
		logic [31:0]           size;
	} mount_evt_t;

	typedef struct packed {
		logic              toggle;
		logic signed [8:0] dx;
		logic signed [8:0] dy;
		logic [1:0]        buttons;
	} mouse_pkt_t;

endpackage

// File: verilog/sector_buffer.sv
`timescale 1ns/1ps

module sector_buffer #(
	parameter int SECTOR_AW = 9
) (
	input  logic                 clk_sys,

	// Host side
	input  logic [SECTOR_AW-1:0] a_addr_i,
	input  logic                 a_wr_i,
	input  logic [7:0]           a_wdata_i,
	output logic [7:0]           a_rdata_o,

	// Firmware side
	input  logic [SECTOR_AW-1:0] b_addr_i,
	input  logic                 b_wr_i,
	input  logic [7:0]           b_wdata_i,
	output logic [7:0]           b_rdata_o
);

	logic [7:0] mem [2**SECTOR_AW];

	// Reads return the byte held before a write on the same edge
	always_ff @(posedge clk_sys) begin
		if (a_wr_i) begin
			mem[a_addr_i] <= a_wdata_i;
		end
		if (b_wr_i) begin
			mem[b_addr_i] <= b_wdata_i;
		end
		a_rdata_o <= mem[a_addr_i];
		b_rdata_o <= mem[b_addr_i];
	end

endmodule

// File: verilog/disk_bridge.sv
`timescale 1ns/1ps

module disk_bridge
	import a8_io_pkg::*;
#(
	parameter int SECTOR_AW = 9
) (
	input  logic                  clk_sys,
	input  logic                  areset,

	input  fw_cmd_t               fw_cmd_i,
	output fw_status_t            fw_status_o,
	output logic [31:0]           fw_rdata_o,

	output logic [NUM_DRIVES-1:0] blk_rd_o,
	output logic [NUM_DRIVES-1:0] blk_wr_o,
	output logic [31:0]           blk_lba_o,
	input  logic                  blk_ack_i,

	input  logic [SECTOR_AW-1:0]  host_addr_i,
	input  logic                  host_wr_i,
	input  logic [7:0]            host_wdata_i,
	output logic [7:0]            host_rdata_o,

	input  mount_evt_t            mount_i,
	input  logic [1:0]            file_type_i
);

	// Sampled strobes and their previous values
	logic lba_q;
	logic blk_rd_q, blk_rd_q2, blk_wr_q, blk_wr_q2;
	logic dat_wr_q, dat_wr_q2, dat_rd_q, dat_rd_q2;
	logic io_rst_q, io_rst_q2;
	logic ack_q, ack_q2;
	logic mnt_q;

	logic blk_rd_rise, blk_wr_rise, dat_wr_rise, dat_rd_fall, io_rst_rise;
	logic ack_fall, mnt_any, mnt_rise;

	logic [SECTOR_AW-1:0] buf_addr;
	logic                 buf_wr;
	logic                 adv_q;
	logic [7:0]           buf_rdata;

	logic             io_done;
	logic             mounted;
	logic [DRV_W-1:0] mnt_top;
	logic [DRV_W-1:0] st_file;
	logic [1:0]       st_type;
	logic             st_ro;
	logic [31:0]      img_size;

	// ==========================================================================
	// Strobe edge detection
	// ==========================================================================

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			{lba_q, blk_rd_q, blk_rd_q2, blk_wr_q, blk_wr_q2} <= '0;
			{dat_wr_q, dat_wr_q2, dat_rd_q, dat_rd_q2} <= '0;
			{io_rst_q, io_rst_q2, ack_q, ack_q2, mnt_q} <= '0;
		end else begin
			lba_q     <= fw_cmd_i.lba_sel;
			blk_rd_q  <= fw_cmd_i.block_rd;
			blk_rd_q2 <= blk_rd_q;
			blk_wr_q  <= fw_cmd_i.block_wr;
			blk_wr_q2 <= blk_wr_q;
			dat_wr_q  <= fw_cmd_i.data_wr;
			dat_wr_q2 <= dat_wr_q;
			dat_rd_q  <= fw_cmd_i.data_rd;
			dat_rd_q2 <= dat_rd_q;
			io_rst_q  <= fw_cmd_i.io_reset;
			io_rst_q2 <= io_rst_q;
			ack_q     <= blk_ack_i;
			ack_q2    <= ack_q;
			mnt_q     <= mnt_any;
		end
	end

	assign blk_rd_rise = blk_rd_q & ~blk_rd_q2;
	assign blk_wr_rise = blk_wr_q & ~blk_wr_q2;
	assign dat_wr_rise = dat_wr_q & ~dat_wr_q2;
	assign dat_rd_fall = ~dat_rd_q & dat_rd_q2;
	assign io_rst_rise = io_rst_q & ~io_rst_q2;
	assign ack_fall    = ~ack_q & ack_q2;
	assign mnt_any     = |mount_i.mount;
	assign mnt_rise    = mnt_any & ~mnt_q;

	// ==========================================================================
	// Sector buffer and its firmware address counter
	// ==========================================================================

	assign buf_wr = dat_wr_rise & ~lba_q;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			buf_addr <= '0;
			adv_q    <= 1'b0;
		end else begin
			adv_q <= buf_wr;
			if (adv_q || dat_rd_fall) begin
				buf_addr <= buf_addr + 1'b1;
			end
			if (io_rst_rise) begin
				buf_addr <= '0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (dat_wr_rise && lba_q) begin
			blk_lba_o <= fw_cmd_i.data;
		end
	end

	sector_buffer #(
		.SECTOR_AW(SECTOR_AW)
	) u_sector_buffer (
		.clk_sys  (clk_sys),
		.a_addr_i (host_addr_i),
		.a_wr_i   (host_wr_i),
		.a_wdata_i(host_wdata_i),
		.a_rdata_o(host_rdata_o),
		.b_addr_i (buf_addr),
		.b_wr_i   (buf_wr),
		.b_wdata_i(fw_cmd_i.data[7:0]),
		.b_rdata_o(buf_rdata)
	);

	assign fw_rdata_o = lba_q ? img_size : {24'h0, buf_rdata};

	// ==========================================================================
	// Four-phase block request
	// ==========================================================================

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			blk_rd_o <= '0;
			blk_wr_o <= '0;
			io_done  <= 1'b0;
		end else begin
			if (blk_rd_rise) begin
				blk_rd_o[fw_cmd_i.drv_num] <= 1'b1;
				io_done <= 1'b0;
			end
			if (blk_wr_rise) begin
				blk_wr_o[fw_cmd_i.drv_num] <= 1'b1;
				io_done <= 1'b0;
			end
			// Host has taken the request
			if (blk_ack_i) begin
				blk_rd_o <= '0;
				blk_wr_o <= '0;
			end
			if (ack_fall) begin
				io_done <= 1'b1;
			end
		end
	end

	// ==========================================================================
	// Mount capture
	// ==========================================================================

	// Highest mounted drive wins
	always_comb begin
		mnt_top = '0;
		for (int i = 0; i < NUM_DRIVES; i++) begin
			if (mount_i.mount[i]) begin
				mnt_top = DRV_W'(i);
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			mounted <= 1'b0;
		end else if (mnt_rise) begin
			mounted <= ~mounted;
		end
	end

	// Drives 4 and 5 are always read-only
	always_ff @(posedge clk_sys) begin
		if (mnt_rise) begin
			st_file  <= mnt_top;
			st_type  <= file_type_i;
			st_ro    <= mount_i.read_only | mount_i.mount[4] | mount_i.mount[5];
			img_size <= mount_i.size;
		end
	end

	assign fw_status_o = '{
		read_only: st_ro,
		file_type: st_type,
		file_no:   st_file,
		mounted:   mounted,
		io_done:   io_done
	};

	a_rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (areset)
		!((|blk_rd_o) && (|blk_wr_o)))
		else $error("block read and write requests pending together");

	a_req_drop_on_ack: assert property (@(posedge clk_sys) disable iff (areset)
		blk_ack_i ##1 blk_ack_i |-> ((blk_rd_o == '0) && (blk_wr_o == '0)))
		else $error("block request still set on second cycle of ack");

endmodule

// File: verilog/mouse_paddle.sv
`timescale 1ns/1ps

module mouse_paddle
	import a8_io_pkg::*;
(
	input  logic              clk_sys,
	input  logic              areset,

	input  mouse_pkt_t        mouse_i,
	input  logic [15:0]       stick_i,
	input  logic [1:0]        buttons_i,
	input  logic              cpu_halt_i,

	output logic signed [7:0] paddle_x_o,
	output logic signed [7:0] paddle_y_o,
	output logic [1:0]        fire_o
);

	logic              tog_q, tog_q2;
	logic signed [8:0] dx_q, dy_q;
	logic signed [7:0] pos_x, pos_y;
	logic              emu;
	logic              pkt_stb;
	logic              takeover;

	// Limit one packet's movement
	function automatic logic signed [8:0] step_clamp(input logic signed [8:0] d);
		if (d > MOUSE_STEP_MAX) begin
			return 9'(MOUSE_STEP_MAX);
		end
		if (d < -MOUSE_STEP_MAX) begin
			return -9'(MOUSE_STEP_MAX);
		end
		return d;
	endfunction

	function automatic logic signed [7:0] axis_add(input logic signed [7:0] pos,
		input logic signed [8:0] d);
		logic signed [9:0] sum;
		sum = pos + d;
		if (sum > AXIS_MAX) begin
			return 8'(AXIS_MAX);
		end
		if (sum < AXIS_MIN) begin
			return 8'(AXIS_MIN);
		end
		return sum[7:0];
	endfunction

	assign pkt_stb  = tog_q ^ tog_q2;
	assign takeover = (stick_i != '0) || cpu_halt_i;

	// Deltas sampled together with the toggle
	always_ff @(posedge clk_sys) begin
		dx_q <= mouse_i.dx;
		dy_q <= mouse_i.dy;
	end

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			tog_q  <= mouse_i.toggle;
			tog_q2 <= mouse_i.toggle;
			emu    <= 1'b0;
			pos_x  <= '0;
			pos_y  <= '0;
		end else begin
			tog_q  <= mouse_i.toggle;
			tog_q2 <= tog_q;
			// Real stick or halted CPU wins over a packet
			if (takeover) begin
				emu   <= 1'b0;
				pos_x <= '0;
				pos_y <= '0;
			end else if (pkt_stb) begin
				emu   <= 1'b1;
				pos_x <= axis_add(pos_x, step_clamp(dx_q));
				pos_y <= axis_add(pos_y, step_clamp(dy_q));
			end
		end
	end

	assign paddle_x_o = emu ? pos_x : stick_i[7:0];
	assign paddle_y_o = emu ? pos_y : stick_i[15:8];
	assign fire_o     = emu ? mouse_i.buttons : buttons_i;

endmodule

// File: verilog/os_rom_loader.sv
`timescale 1ns/1ps

module os_rom_loader
	import a8_io_pkg::*;
#(
	parameter int ROM_AW = 14
) (
	input  logic              clk_sys,
	input  logic              areset,

	input  logic              ld_wr_i,
	input  logic [ROM_AW-1:0] ld_addr_i,
	input  logic [7:0]        ld_data_i,

	input  logic [ROM_AW-1:0] rom_addr_i,
	output logic [7:0]        rom_data_o
);

	localparam logic [ROM_AW-1:0] ROM_LAST = '1;

	logic [7:0]        rom_mem [2**ROM_AW];
	logic [ROM_AW-1:0] img_off;
	logic [ROM_AW-1:0] rd_idx;
	logic              loaded;
	logic [7:0]        rd_data;
	logic              rd_hit;

	// Image is kept from address 0 and shifted up on read by the offset
	assign rd_idx = rom_addr_i - img_off;

	always_ff @(posedge clk_sys) begin
		if (ld_wr_i) begin
			rom_mem[ld_addr_i] <= ld_data_i;
			img_off <= ROM_LAST - ld_addr_i;
		end
		rd_data <= rom_mem[rd_idx];
	end

	// Range check travels alongside the RAM read
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			loaded <= 1'b0;
			rd_hit <= 1'b0;
		end else begin
			if (ld_wr_i) begin
				loaded <= 1'b1;
			end
			rd_hit <= loaded && (rom_addr_i >= img_off);
		end
	end

	assign rom_data_o = rd_hit ? rd_data : ROM_PAD_BYTE;

	// A new load restarts at address 0
	a_ld_addr_rising: assert property (@(posedge clk_sys) disable iff (areset)
		(ld_wr_i && loaded && (ld_addr_i != '0)) |-> ((ROM_LAST - ld_addr_i) < img_off))
		else $error("ROM load address did not increase");

endmodule

// File: verilog/a8_io_top.sv
`timescale 1ns/1ps

module a8_io_top
	import a8_io_pkg::*;
#(
	parameter int SECTOR_AW = 9,
	parameter int ROM_AW    = 14
) (
	input  logic                  clk_sys,
	input  logic                  areset,

	// Firmware register port
	input  fw_cmd_t               fw_cmd_i,
	output fw_status_t            fw_status_o,
	output logic [31:0]           fw_rdata_o,

	// Host block transfer
	output logic [NUM_DRIVES-1:0] blk_rd_o,
	output logic [NUM_DRIVES-1:0] blk_wr_o,
	output logic [31:0]           blk_lba_o,
	input  logic                  blk_ack_i,
	input  logic [SECTOR_AW-1:0]  host_addr_i,
	input  logic                  host_wr_i,
	input  logic [7:0]            host_wdata_i,
	output logic [7:0]            host_rdata_o,
	input  mount_evt_t            mount_i,
	input  logic [1:0]            file_type_i,

	// Pointer and stick
	input  mouse_pkt_t            mouse_i,
	input  logic [15:0]           stick_i,
	input  logic [1:0]            buttons_i,
	input  logic                  cpu_halt_i,
	output logic signed [7:0]     paddle_x_o,
	output logic signed [7:0]     paddle_y_o,
	output logic [1:0]            fire_o,

	// OS ROM
	input  logic                  ld_wr_i,
	input  logic [ROM_AW-1:0]     ld_addr_i,
	input  logic [7:0]            ld_data_i,
	input  logic [ROM_AW-1:0]     rom_addr_i,
	output logic [7:0]            rom_data_o
);

	disk_bridge #(
		.SECTOR_AW(SECTOR_AW)
	) u_disk_bridge (
		.clk_sys     (clk_sys),
		.areset      (areset),
		.fw_cmd_i    (fw_cmd_i),
		.fw_status_o (fw_status_o),
		.fw_rdata_o  (fw_rdata_o),
		.blk_rd_o    (blk_rd_o),
		.blk_wr_o    (blk_wr_o),
		.blk_lba_o   (blk_lba_o),
		.blk_ack_i   (blk_ack_i),
		.host_addr_i (host_addr_i),
		.host_wr_i   (host_wr_i),
		.host_wdata_i(host_wdata_i),
		.host_rdata_o(host_rdata_o),
		.mount_i     (mount_i),
		.file_type_i (file_type_i)
	);

	mouse_paddle u_mouse_paddle (
		.clk_sys   (clk_sys),
		.areset    (areset),
		.mouse_i   (mouse_i),
		.stick_i   (stick_i),
		.buttons_i (buttons_i),
		.cpu_halt_i(cpu_halt_i),
		.paddle_x_o(paddle_x_o),
		.paddle_y_o(paddle_y_o),
		.fire_o    (fire_o)
	);

	os_rom_loader #(
		.ROM_AW(ROM_AW)
	) u_os_rom_loader (
		.clk_sys   (clk_sys),
		.areset    (areset),
		.ld_wr_i   (ld_wr_i),
		.ld_addr_i (ld_addr_i),
		.ld_data_i (ld_data_i),
		.rom_addr_i(rom_addr_i),
		.rom_data_o(rom_data_o)
	);

endmodule

// File: test/a8_io_checker.sv
`timescale 1ns/1ps

module a8_io_checker
	import a8_io_pkg::*;
#(
	parameter int SECTOR_AW = 9,
	parameter int ROM_AW    = 14
) (
	input logic                  clk_sys,
	input logic                  areset,
	input fw_cmd_t               fw_cmd_i,
	input logic [31:0]           fw_rdata_o,
	input logic [NUM_DRIVES-1:0] blk_rd_o,
	input logic [NUM_DRIVES-1:0] blk_wr_o,
	input logic                  blk_ack_i,
	input logic [SECTOR_AW-1:0]  host_addr_i,
	input logic                  host_wr_i,
	input logic [7:0]            host_wdata_i,
	input logic [7:0]            host_rdata_o,
	input mouse_pkt_t            mouse_i,
	input logic [15:0]           stick_i,
	input logic [1:0]            buttons_i,
	input logic                  cpu_halt_i,
	input logic signed [7:0]     paddle_x_o,
	input logic signed [7:0]     paddle_y_o,
	input logic [1:0]            fire_o,
	input logic                  ld_wr_i,
	input logic [ROM_AW-1:0]     ld_addr_i,
	input logic [7:0]            ld_data_i,
	input logic [ROM_AW-1:0]     rom_addr_i,
	input logic [7:0]            rom_data_o
);

	int errors = 0;
	int checks = 0;

	// Mouse model
	int          m_x, m_y;
	logic        m_emu;
	logic        prev_tog;
	logic [15:0] prev_stick;
	int          quiet;
	logic [7:0]  ex, ey;
	logic [1:0]  ef;

	// Shadow of the sector buffer and of the firmware address counter
	logic [7:0] buf_shadow [int];
	int         fw_cnt;
	logic       prev_wr, prev_rd, prev_rst, prev_ack;

	// ROM shadow with the image kept by load index
	logic [7:0] rom_img [int];
	logic       rom_loaded;
	int         rom_off;
	logic       r_pend, r_known;
	logic [7:0] r_exp;

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic report_fault(input string msg);
		errors++;
		$display("%s at %0t", msg, $time);
	endtask

	task automatic check_host_byte();
		if (!buf_shadow.exists(int'(host_addr_i))) begin
			report_fault("Host read a sector buffer byte that was never written");
		end else begin
			check_val("host_rdata_o", {24'h0, host_rdata_o},
				{24'h0, buf_shadow[int'(host_addr_i)]});
		end
	endtask

	task automatic check_fw_byte();
		if (!buf_shadow.exists(fw_cnt)) begin
			report_fault("Firmware read a sector buffer byte that was never written");
		end else begin
			check_val("fw_rdata_o", fw_rdata_o, {24'h0, buf_shadow[fw_cnt]});
		end
	endtask

	// Clamp the step, then saturate the axis
	function automatic int axis_step(input int pos, input int d);
		int c;
		int s;
		c = d;
		if (c > MOUSE_STEP_MAX) c = MOUSE_STEP_MAX;
		if (c < -MOUSE_STEP_MAX) c = -MOUSE_STEP_MAX;
		s = pos + c;
		if (s > AXIS_MAX) s = AXIS_MAX;
		if (s < AXIS_MIN) s = AXIS_MIN;
		return s;
	endfunction

	// ==========================================================================
	// Paddle outputs, checked once they have settled
	// ==========================================================================

	always @(posedge clk_sys) begin
		if (areset) begin
			m_x        = 0;
			m_y        = 0;
			m_emu      = 1'b0;
			quiet      = 0;
			prev_tog   = mouse_i.toggle;
			prev_stick = stick_i;
		end else begin
			if (quiet >= 3) begin
				ex = m_emu ? 8'(m_x) : stick_i[7:0];
				ey = m_emu ? 8'(m_y) : stick_i[15:8];
				ef = m_emu ? mouse_i.buttons : buttons_i;
				check_val("paddle_x_o", {24'h0, paddle_x_o}, {24'h0, ex});
				check_val("paddle_y_o", {24'h0, paddle_y_o}, {24'h0, ey});
				check_val("fire_o", {30'h0, fire_o}, {30'h0, ef});
			end
			if (stick_i != 16'h0 || cpu_halt_i) begin
				m_x   = 0;
				m_y   = 0;
				m_emu = 1'b0;
			end else if (mouse_i.toggle != prev_tog) begin
				m_x   = axis_step(m_x, int'(mouse_i.dx));
				m_y   = axis_step(m_y, int'(mouse_i.dy));
				m_emu = 1'b1;
			end
			if (mouse_i.toggle != prev_tog || stick_i != prev_stick || cpu_halt_i) begin
				quiet = 0;
			end else if (quiet < 3) begin
				quiet++;
			end
			prev_tog   = mouse_i.toggle;
			prev_stick = stick_i;
		end
	end

	// ==========================================================================
	// Sector buffer shadow and block handshake
	// ==========================================================================

	always @(posedge clk_sys) begin
		if (areset) begin
			fw_cnt   = 0;
			prev_wr  = 1'b0;
			prev_rd  = 1'b0;
			prev_rst = 1'b0;
			prev_ack = 1'b0;
		end else begin
			if (host_wr_i) begin
				buf_shadow[int'(host_addr_i)] = host_wdata_i;
			end
			if (fw_cmd_i.io_reset && !prev_rst) begin
				fw_cnt = 0;
			end
			if (fw_cmd_i.data_wr && !prev_wr && !fw_cmd_i.lba_sel) begin
				buf_shadow[fw_cnt] = fw_cmd_i.data[7:0];
				fw_cnt = (fw_cnt + 1) % (2**SECTOR_AW);
			end
			if (!fw_cmd_i.data_rd && prev_rd) begin
				fw_cnt = (fw_cnt + 1) % (2**SECTOR_AW);
			end
			if (prev_ack && blk_ack_i && (blk_rd_o != '0 || blk_wr_o != '0)) begin
				report_fault("Block request still pending on the second cycle of host ack");
			end
			prev_wr  = fw_cmd_i.data_wr;
			prev_rd  = fw_cmd_i.data_rd;
			prev_rst = fw_cmd_i.io_reset;
			prev_ack = blk_ack_i;
		end
	end

	// ==========================================================================
	// ROM reads, one expected byte in flight per cycle
	// ==========================================================================

	always @(posedge clk_sys) begin
		if (areset) begin
			rom_loaded = 1'b0;
			rom_off    = 0;
			r_pend     = 1'b0;
		end else begin
			if (r_pend && r_known) begin
				check_val("rom_data_o", {24'h0, rom_data_o}, {24'h0, r_exp});
			end
			r_pend  = 1'b1;
			r_known = 1'b1;
			r_exp   = ROM_PAD_BYTE;
			if (rom_loaded && int'(rom_addr_i) >= rom_off) begin
				r_known = rom_img.exists(int'(rom_addr_i) - rom_off);
				if (r_known) begin
					r_exp = rom_img[int'(rom_addr_i) - rom_off];
				end
			end
			if (ld_wr_i) begin
				rom_img[int'(ld_addr_i)] = ld_data_i;
				rom_off    = (2**ROM_AW - 1) - int'(ld_addr_i);
				rom_loaded = 1'b1;
			end
		end
	end

endmodule

// File: test/tb_a8_io.sv
`timescale 1ns/1ps

module tb_a8_io
	import a8_io_pkg::*;
();

	localparam int SECTOR_AW = 9;
	localparam int ROM_AW    = 14;

	logic                  clk_sys;
	logic                  areset;
	fw_cmd_t               fw_cmd;
	fw_status_t            fw_status;
	logic [31:0]           fw_rdata;
	logic [NUM_DRIVES-1:0] blk_rd;
	logic [NUM_DRIVES-1:0] blk_wr;
	logic [31:0]           blk_lba;
	logic                  blk_ack;
	logic [SECTOR_AW-1:0]  host_addr;
	logic                  host_wr;
	logic [7:0]            host_wdata;
	logic [7:0]            host_rdata;
	mount_evt_t            mount;
	logic [1:0]            file_type;
	mouse_pkt_t            mouse;
	logic [15:0]           stick;
	logic [1:0]            buttons;
	logic                  cpu_halt;
	logic signed [7:0]     paddle_x;
	logic signed [7:0]     paddle_y;
	logic [1:0]            fire;
	logic                  ld_wr;
	logic [ROM_AW-1:0]     ld_addr;
	logic [7:0]            ld_data;
	logic [ROM_AW-1:0]     rom_addr;
	logic [7:0]            rom_data;

	int          seed = 32'h6bc647b0;
	string       recs[$];
	logic [31:0] lba_exp;
	logic        mnt_exp;

	a8_io_top #(
		.SECTOR_AW(SECTOR_AW),
		.ROM_AW   (ROM_AW)
	) UUT (
		.clk_sys     (clk_sys),
		.areset      (areset),
		.fw_cmd_i    (fw_cmd),
		.fw_status_o (fw_status),
		.fw_rdata_o  (fw_rdata),
		.blk_rd_o    (blk_rd),
		.blk_wr_o    (blk_wr),
		.blk_lba_o   (blk_lba),
		.blk_ack_i   (blk_ack),
		.host_addr_i (host_addr),
		.host_wr_i   (host_wr),
		.host_wdata_i(host_wdata),
		.host_rdata_o(host_rdata),
		.mount_i     (mount),
		.file_type_i (file_type),
		.mouse_i     (mouse),
		.stick_i     (stick),
		.buttons_i   (buttons),
		.cpu_halt_i  (cpu_halt),
		.paddle_x_o  (paddle_x),
		.paddle_y_o  (paddle_y),
		.fire_o      (fire),
		.ld_wr_i     (ld_wr),
		.ld_addr_i   (ld_addr),
		.ld_data_i   (ld_data),
		.rom_addr_i  (rom_addr),
		.rom_data_o  (rom_data)
	);

	a8_io_checker #(
		.SECTOR_AW(SECTOR_AW),
		.ROM_AW   (ROM_AW)
	) u_chk (
		.clk_sys     (clk_sys),
		.areset      (areset),
		.fw_cmd_i    (fw_cmd),
		.fw_rdata_o  (fw_rdata),
		.blk_rd_o    (blk_rd),
		.blk_wr_o    (blk_wr),
		.blk_ack_i   (blk_ack),
		.host_addr_i (host_addr),
		.host_wr_i   (host_wr),
		.host_wdata_i(host_wdata),
		.host_rdata_o(host_rdata),
		.mouse_i     (mouse),
		.stick_i     (stick),
		.buttons_i   (buttons),
		.cpu_halt_i  (cpu_halt),
		.paddle_x_o  (paddle_x),
		.paddle_y_o  (paddle_y),
		.fire_o      (fire),
		.ld_wr_i     (ld_wr),
		.ld_addr_i   (ld_addr),
		.ld_data_i   (ld_data),
		.rom_addr_i  (rom_addr),
		.rom_data_o  (rom_data)
	);

	always #50 clk_sys = ~clk_sys;

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	// ==========================================================================
	// Mouse and stick
	// ==========================================================================

	task automatic send_packet(input logic [8:0] dx, input logic [8:0] dy,
		input logic [1:0] btn);
		mouse.dx      = dx;
		mouse.dy      = dy;
		mouse.buttons = btn;
		mouse.toggle  = ~mouse.toggle;
		wait_cycles(5);
	endtask

	task automatic stick_cycle(input logic [15:0] v);
		stick   = v;
		buttons = 2'b01;
		wait_cycles(5);
		u_chk.check_val("paddle_x_o", {24'h0, paddle_x}, {24'h0, v[7:0]});
		u_chk.check_val("paddle_y_o", {24'h0, paddle_y}, {24'h0, v[15:8]});
		u_chk.check_val("fire_o", {30'h0, fire}, 32'h1);
		stick   = '0;
		buttons = '0;
		wait_cycles(5);
	endtask

	task automatic halt_pulse();
		cpu_halt = 1'b1;
		wait_cycles(1);
		cpu_halt = 1'b0;
		wait_cycles(5);
		u_chk.check_val("paddle_x_o", {24'h0, paddle_x}, 32'h0);
		u_chk.check_val("paddle_y_o", {24'h0, paddle_y}, 32'h0);
	endtask

	// ==========================================================================
	// Disk bridge
	// ==========================================================================

	task automatic write_lba(input logic [31:0] v);
		fw_cmd.lba_sel = 1'b1;
		fw_cmd.data    = v;
		fw_cmd.data_wr = 1'b1;
		wait_cycles(2);
		fw_cmd.data_wr = 1'b0;
		wait_cycles(2);
		fw_cmd.lba_sel = 1'b0;
		lba_exp        = v;
		wait_cycles(1);
	endtask

	task automatic block_request(input logic wr, input logic [2:0] drv, input int hold);
		logic [7:0] want;
		int         i;
		want           = 8'b1 << drv;
		fw_cmd.drv_num = drv;
		if (wr) begin
			fw_cmd.block_wr = 1'b1;
		end else begin
			fw_cmd.block_rd = 1'b1;
		end
		wait_cycles(3);
		u_chk.check_val("blk_rd_o", {24'h0, blk_rd}, wr ? 32'h0 : {24'h0, want});
		u_chk.check_val("blk_wr_o", {24'h0, blk_wr}, wr ? {24'h0, want} : 32'h0);
		u_chk.check_val("io_done", {31'h0, fw_status.io_done}, 32'h0);
		u_chk.check_val("blk_lba_o", blk_lba, lba_exp);
		blk_ack = 1'b1;
		wait_cycles(hold);
		u_chk.check_val("blk_rd_o", {24'h0, blk_rd}, 32'h0);
		u_chk.check_val("blk_wr_o", {24'h0, blk_wr}, 32'h0);
		u_chk.check_val("io_done", {31'h0, fw_status.io_done}, 32'h0);
		blk_ack         = 1'b0;
		fw_cmd.block_rd = 1'b0;
		fw_cmd.block_wr = 1'b0;
		i = 0;
		while (!fw_status.io_done && i < 20) begin
			wait_cycles(1);
			i++;
		end
		if (!fw_status.io_done) begin
			u_chk.report_fault("io_done did not rise after the host dropped ack");
		end
	endtask

	task automatic pulse_io_reset();
		fw_cmd.io_reset = 1'b1;
		wait_cycles(2);
		fw_cmd.io_reset = 1'b0;
		wait_cycles(3);
	endtask

	// Firmware fills the buffer, host reads it back from address 0
	task automatic fw_fill(input int n);
		pulse_io_reset();
		for (int i = 0; i < n; i++) begin
			fw_cmd.data    = 32'($random(seed));
			fw_cmd.data_wr = 1'b1;
			wait_cycles(2);
			fw_cmd.data_wr = 1'b0;
			wait_cycles(3);
		end
		for (int i = 0; i < n; i++) begin
			host_addr = SECTOR_AW'(i);
			wait_cycles(2);
			u_chk.check_host_byte();
		end
	endtask

	task automatic host_fill(input int n);
		for (int i = 0; i < n; i++) begin
			host_addr  = SECTOR_AW'(i);
			host_wdata = 8'($random(seed));
			host_wr    = 1'b1;
			wait_cycles(1);
		end
		host_wr = 1'b0;
		pulse_io_reset();
		for (int i = 0; i < n; i++) begin
			u_chk.check_fw_byte();
			fw_cmd.data_rd = 1'b1;
			wait_cycles(2);
			fw_cmd.data_rd = 1'b0;
			wait_cycles(4);
		end
	endtask

	task automatic mount_event(input logic [7:0] vec, input logic ro, input logic [31:0] size,
		input logic [1:0] ftype, input logic [2:0] exp_file, input logic exp_ro);
		mount.mount     = vec;
		mount.read_only = ro;
		mount.size      = size;
		file_type       = ftype;
		wait_cycles(2);
		mount.mount = '0;
		wait_cycles(3);
		mnt_exp = ~mnt_exp;
		u_chk.check_val("fw_status_o.file_no", {29'h0, fw_status.file_no}, {29'h0, exp_file});
		u_chk.check_val("fw_status_o.read_only", {31'h0, fw_status.read_only}, {31'h0, exp_ro});
		u_chk.check_val("fw_status_o.file_type", {30'h0, fw_status.file_type}, {30'h0, ftype});
		u_chk.check_val("fw_status_o.mounted", {31'h0, fw_status.mounted}, {31'h0, mnt_exp});
		fw_cmd.lba_sel = 1'b1;
		wait_cycles(2);
		u_chk.check_val("fw_rdata_o", fw_rdata, size);
		fw_cmd.lba_sel = 1'b0;
		wait_cycles(1);
	endtask

	// ==========================================================================
	// OS ROM
	// ==========================================================================

	task automatic load_rom(input int len, input logic [7:0] base);
		for (int i = 0; i < len; i++) begin
			ld_addr = ROM_AW'(i);
			ld_data = base + 8'(i);
			ld_wr   = 1'b1;
			wait_cycles(1);
		end
		ld_wr = 1'b0;
		wait_cycles(2);
	endtask

	task automatic read_rom(input logic [ROM_AW-1:0] addr, input logic [7:0] exp);
		rom_addr = addr;
		wait_cycles(2);
		u_chk.check_val("rom_data_o", {24'h0, rom_data}, {24'h0, exp});
	endtask

	// Back-to-back reads around the image start
	task automatic rom_burst(input int n);
		repeat (n) begin
			rom_addr = 14'h3fe0 | ROM_AW'($random(seed) & 31);
			wait_cycles(1);
		end
	endtask

	task automatic run_record(input string line);
		logic [7:0]  op;
		logic [31:0] a, b, c, d, e, f;
		void'($sscanf(line, "%c %h %h %h %h %h %h", op, a, b, c, d, e, f));
		case (op)
			"M": begin
				send_packet(a[8:0], b[8:0], c[1:0]);
				u_chk.check_val("paddle_x_o", {24'h0, paddle_x}, {24'h0, d[7:0]});
				u_chk.check_val("paddle_y_o", {24'h0, paddle_y}, {24'h0, e[7:0]});
				u_chk.check_val("fire_o", {30'h0, fire}, {30'h0, c[1:0]});
			end
			"P": repeat (a) send_packet(b[8:0], c[8:0], 2'b00);
			"R": repeat (a) send_packet(9'($random(seed)), 9'($random(seed)),
				2'($random(seed)));
			"S": stick_cycle(a[15:0]);
			"H": halt_pulse();
			"L": write_lba(a);
			"B": block_request(a[0], b[2:0], c);
			"W": fw_fill(a);
			"F": host_fill(a);
			"N": mount_event(a[7:0], b[0], c, d[1:0], e[2:0], f[0]);
			"O": load_rom(a, b[7:0]);
			"Q": read_rom(a[ROM_AW-1:0], b[7:0]);
			"G": rom_burst(a);
			default: u_chk.report_fault($sformatf("Unknown record in input file: %s", line));
		endcase
	endtask

	initial begin
		int    fd;
		string line;
		clk_sys   = 1'b0;
		areset    = 1'b1;
		fw_cmd    = '0;
		blk_ack   = 1'b0;
		host_addr = '0;
		host_wr   = 1'b0;
		host_wdata = '0;
		mount     = '0;
		file_type = '0;
		mouse     = '0;
		stick     = '0;
		buttons   = '0;
		cpu_halt  = 1'b0;
		ld_wr     = 1'b0;
		ld_addr   = '0;
		ld_data   = '0;
		rom_addr  = '0;
		lba_exp   = '0;
		mnt_exp   = 1'b0;

		fd = $fopen("test/a8_io_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file test/a8_io_input.txt");
			$display("Simulation failed");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
					recs.push_back(line);
				end
			end
			$fclose(fd);

			// Watchdog sized from the number of records
			fork
				begin
					#((recs.size() * 40 + 200) * 100);
					$display("Timeout: run exceeded %0d cycles", recs.size() * 40 + 200);
					$display("Simulation failed");
					$finish;
				end
			join_none

			wait_cycles(2);
			areset = 1'b0;
			wait_cycles(2);
			foreach (recs[i]) begin
				run_record(recs[i]);
			end
			wait_cycles(5);
			$display("Checks run: %0d, errors: %0d", u_chk.checks, u_chk.errors);
			if (u_chk.errors == 0) begin
				$display("Simulation completed successfully");
			end else begin
				$display("Simulation failed");
			end
			$finish;
		end
	end

endmodule

// File: test/a8_io_input.txt
# Columns: opcode, then hex operands as listed for each opcode
# M dx dy btn exp_x exp_y | P count dx dy | R count | S stick | H | L lba | B wr drive ack_cycles | W count | F count | N mount ro size type exp_file exp_ro | O len base | Q addr exp | G count
Q 0000 ff
Q 3fff ff
G 8
M 005 003 1 05 03
M 1f4 00c 2 fb 0d
M 0ff 1f0 0 05 03
P 6 00a 00a
P 6 00a 00a
P 6 00c 00a
M 001 000 3 7f 7f
P 6 1f6 1f6
P 6 1f6 1f6
P 6 1f0 1f6
P 6 1f6 1f6
P 6 1f6 1f6
M 1ff 1ff 2 80 80
R 5
S 1234
M 002 1fe 3 02 fe
R 4
H
M 1fd 004 1 fd 04
L 00012345
B 0 3 2
B 1 5 c
L 0badf00d
B 0 7 20
B 1 0 3
W 4
F 4
W 3
N 01 0 00001000 1 0 0
N 30 0 00002000 2 5 1
N 84 1 0001a400 3 7 1
N 06 0 00000200 0 2 0
O 10 a0
Q 3ff0 a0
Q 3ff7 a7
Q 3fff af
Q 3fef ff
Q 0000 ff
G 20

// File: compile.f
verilog/a8_io_pkg.sv
verilog/sector_buffer.sv
verilog/disk_bridge.sv
verilog/mouse_paddle.sv
verilog/os_rom_loader.sv
verilog/a8_io_top.sv
test/a8_io_checker.sv
test/tb_a8_io.sv

// File: Makefile
# Verilator build for the I/O subsystem testbench

TOP       ?= tb_a8_io
FILELIST  ?= compile.f
LOG       ?= sim.log
VERILATOR ?= verilator
OBJDIR    ?= obj_dir
PASS_MSG  := Simulation completed successfully

VFLAGS ?= --sv --timing --assert -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
